//--- Bender.yml
package:
  name: umi_fifo_flex

sources:
  - umi_pkg.sv
  - umi_split.sv
  - umi_async_fifo.sv
  - umi_fifo_flex.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_umi_fifo_flex.sv

//--- compile.f
umi_pkg.sv
umi_split.sv
umi_async_fifo.sv
umi_fifo_flex.sv
tb_clk_gen.sv
tb_umi_fifo_flex.sv

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen
  #(parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 3
    )
   (output logic clk,
    output logic nreset
    );

   initial
   begin
      clk    = 1'b0;
      nreset = 1'b0;                 // Held from time zero
      forever #(PERIOD/2) clk = ~clk;
   end

   // Release a little after the edge as the other stimulus does
   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk);
      #2 nreset = 1'b1;
   end

endmodule

//--- tb_umi_fifo_flex.sv
`timescale 1ns/1ns

module tb_umi_fifo_flex;

   import umi_pkg::*;

   localparam int AW        = 64;
   localparam int IDW       = 256;
   localparam int ODW       = 64;
   localparam int in_bytes  = IDW / 8;
   localparam int out_bytes = ODW / 8;

   logic umi_in_clk, umi_in_nreset, umi_out_clk, umi_out_nreset;
   logic bypass, fifo_full, fifo_empty;
   logic umi_in_valid, umi_in_ready, umi_out_valid, umi_out_ready;
   logic [umi_cw-1:0] umi_in_cmd, umi_out_cmd;
   logic [AW-1:0]     umi_in_dstaddr, umi_in_srcaddr, umi_out_dstaddr, umi_out_srcaddr;
   logic [IDW-1:0]    umi_in_data;
   logic [ODW-1:0]    umi_out_data;

   // Expected pieces in output order
   logic [umi_cw-1:0] exp_cmd[$];
   logic [AW-1:0]     exp_dst[$];
   logic [AW-1:0]     exp_src[$];
   logic [ODW-1:0]    exp_data[$];

   integer seed = 61;
   int errors = 0, checks = 0, tests_run = 0, tests_bad = 0;
   int planned = 0, cycles = 0, rx_pieces = 0, rx_bytes = 0;

   tb_clk_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_in_clk (.clk(umi_in_clk), .nreset(umi_in_nreset));
   tb_clk_gen #(.PERIOD(30), .RESET_CYCLES(3)) u_out_clk (.clk(umi_out_clk), .nreset(umi_out_nreset));

   umi_fifo_flex #(.AW(AW), .IDW(IDW), .ODW(ODW), .DEPTH(4), .SPLIT(1), .BYPASS(0))
   umi_fifo_flex_i (.*);

   //######################################################################
   // Checking and reference model
   //######################################################################

   task automatic check_val(input string name, input logic [IDW-1:0] got,
                            input logic [IDW-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic expect_piece(input logic [umi_cw-1:0] c, input logic [AW-1:0] d,
                               input logic [AW-1:0] s, input logic [ODW-1:0] w);
      exp_cmd.push_back(c);
      exp_dst.push_back(d);
      exp_src.push_back(s);
      exp_data.push_back(w);
      planned++;                    // Also stretches the timeout
   endtask

   // Cut at each output beat boundary of the destination address
   task automatic model_split(input logic [umi_cw-1:0] cmd, input logic [AW-1:0] dst,
                              input logic [AW-1:0] src, input logic [IDW-1:0] data);
      logic [umi_cw-1:0] c;
      logic [AW-1:0]     d;
      logic [AW-1:0]     s;
      logic [IDW-1:0]    w;
      int                nbytes;
      int                room;
      int                elems;
      logic              done;
      c    = cmd;
      d    = dst;
      s    = src;
      w    = data;
      done = 1'b0;
      while (!done)
      begin
         nbytes = (int'(cmd_len(c)) + 1) << cmd_size(c);
         room   = out_bytes - int'(d % AW'(out_bytes));
         if (nbytes <= room)
         begin
            expect_piece(c, d, s, w[ODW-1:0]);   // Last piece keeps eom
            done = 1'b1;
         end
         else
         begin
            elems = room >> cmd_size(c);
            expect_piece(cmd_set_len_eom(c, len_w'(elems - 1), 1'b0), d, s, w[ODW-1:0]);
            c = cmd_set_len_eom(c, len_w'(int'(cmd_len(c)) - elems), cmd_eom(c));
            d = d + AW'(room);
            s = s + AW'(room);
            w = w >> (room * 8);
         end
      end
   endtask

   // Output monitor runs on umi_out_clk in FIFO mode and on umi_in_clk in bypass
   task automatic take_output();
      if (umi_out_valid && umi_out_ready)
      begin
         rx_pieces++;
         rx_bytes += (int'(cmd_len(umi_out_cmd)) + 1) << cmd_size(umi_out_cmd);
         if (exp_cmd.size() == 0)
         begin
            errors++;
            $display("Unexpected transaction on the output at %0t ns", $time);
         end
         else
         begin
            check_val("umi_out_cmd", umi_out_cmd, exp_cmd.pop_front());
            check_val("umi_out_dstaddr", umi_out_dstaddr, exp_dst.pop_front());
            check_val("umi_out_srcaddr", umi_out_srcaddr, exp_src.pop_front());
            check_val("umi_out_data", umi_out_data, exp_data.pop_front());
         end
      end
   endtask

   always @(posedge umi_out_clk) if (!bypass) take_output();
   always @(posedge umi_in_clk) if (bypass) take_output();

   //######################################################################
   // Stimulus helpers
   //######################################################################

   function automatic logic [umi_cw-1:0] make_cmd(input umi_opcode_e op, input int size,
                                                  input int len, input logic eom);
      logic [umi_cw-1:0] c;
      c                         = umi_cw'($random(seed));   // Spare fields random
      c[opcode_lsb +: opcode_w] = op;
      c[size_lsb +: size_w]     = size_w'(size);
      c[len_lsb +: len_w]       = len_w'(len);
      c[eom_pos]                = eom;
      return c;
   endfunction

   function automatic logic [IDW-1:0] rand_data();
      logic [IDW-1:0] w;
      for (int i = 0; i < IDW/32; i++)
         w[i*32 +: 32] = $random(seed);
      return w;
   endfunction

   task automatic drive_txn(input logic [umi_cw-1:0] cmd, input logic [AW-1:0] dst,
                            input logic [AW-1:0] src, input logic [IDW-1:0] data);
      model_split(cmd, dst, src, data);
      @(posedge umi_in_clk);
      #2;
      umi_in_valid   = 1'b1;
      umi_in_cmd     = cmd;
      umi_in_dstaddr = dst;
      umi_in_srcaddr = src;
      umi_in_data    = data;
   endtask

   task automatic wait_accept();
      do
         @(posedge umi_in_clk);
      while (!umi_in_ready);
      #2 umi_in_valid = 1'b0;
   endtask

   task automatic send_txn(input logic [umi_cw-1:0] cmd, input logic [AW-1:0] dst,
                           input logic [AW-1:0] src, input logic [IDW-1:0] data);
      drive_txn(cmd, dst, src, data);
      wait_accept();
   endtask

   task automatic send_random();
      int            size;
      int            len;
      logic [AW-1:0] dst;
      size = $random(seed) & 3;
      len  = ($random(seed) & 255) % (in_bytes >> size);
      dst  = {$random(seed), $random(seed)};
      dst  = dst & ~AW'((1 << size) - 1);      // Element aligned
      send_txn(make_cmd(UMI_REQ_POSTED, size, len, 1'b1), dst,
               {$random(seed), $random(seed)}, rand_data());
   endtask

   task automatic set_out_ready(input logic value);
      @(posedge umi_out_clk);
      #2 umi_out_ready = value;
   endtask

   task automatic wait_drain();
      while (exp_cmd.size() != 0)
         @(posedge umi_in_clk);
      repeat (4) @(posedge umi_in_clk);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("Test %-14s ok", name);
      else
      begin
         tests_bad++;
         $display("Test %-14s had %0d errors", name, errors - errors_before);
      end
      rx_pieces = 0;
      rx_bytes  = 0;
   endtask

   //######################################################################
   // Tests
   //######################################################################

   task automatic test_reset();
      int e0;
      e0 = errors;
      repeat (2) @(posedge umi_in_clk);
      #1;
      check_val("umi_in_ready", umi_in_ready, 0);
      check_val("umi_out_valid", umi_out_valid, 0);
      @(posedge umi_in_nreset);
      repeat (2)
      begin
         @(posedge umi_in_clk);          // Values just before the edge
         check_val("umi_in_ready", umi_in_ready, 0);
         check_val("umi_out_valid", umi_out_valid, 0);
      end
      #1;
      check_val("umi_in_ready", umi_in_ready, 1);
      check_val("fifo_empty", fifo_empty, 1);
      wait (umi_out_nreset === 1'b1);
      report_test("reset", e0);
   endtask

   task automatic test_pass_through();
      int e0;
      e0 = errors;
      send_txn(make_cmd(UMI_REQ_WRITE, 0, 3, 1'b1), 64'h1000, 64'h8000, rand_data());
      wait_drain();
      check_val("pieces", rx_pieces, 1);
      report_test("pass-through", e0);
   endtask

   task automatic test_aligned();
      int e0;
      e0 = errors;
      send_txn(make_cmd(UMI_REQ_WRITE, 0, 31, 1'b1), 64'h2040, 64'h9000, rand_data());
      wait_drain();
      check_val("pieces", rx_pieces, 4);
      report_test("aligned split", e0);
   endtask

   task automatic test_unaligned();
      int e0;
      e0 = errors;
      send_txn(make_cmd(UMI_REQ_WRITE, 0, 31, 1'b1), 64'h3005, 64'ha000, rand_data());
      send_txn(make_cmd(UMI_REQ_POSTED, 1, 15, 1'b1), 64'h4106, 64'hb002, rand_data());
      wait_drain();
      check_val("pieces", rx_pieces, 10);      // 5 from each
      check_val("bytes", rx_bytes, 2 * in_bytes);
      report_test("unaligned", e0);
   endtask

   task automatic test_backpressure();
      int   e0;
      logic saw_full;
      logic saw_stall;
      e0        = errors;
      saw_full  = 1'b0;
      saw_stall = 1'b0;
      set_out_ready(1'b0);
      fork
         for (int i = 0; i < 10; i++)
            send_random();
         begin
            while (!saw_full)
            begin
               @(posedge umi_in_clk);
               saw_full  = fifo_full;
               saw_stall = fifo_full & ~umi_in_ready;
            end
            repeat (10) @(posedge umi_in_clk);
            set_out_ready(1'b1);
         end
      join
      wait_drain();
      check_val("fifo_full seen", saw_full, 1);
      check_val("umi_in_ready low seen", saw_stall, 1);
      report_test("back-pressure", e0);
   endtask

   task automatic test_bypass();
      int e0;
      e0 = errors;
      @(posedge umi_in_clk);
      #2 bypass = 1'b1;
      drive_txn(make_cmd(UMI_REQ_WRITE, 0, 31, 1'b0), 64'h5005, 64'hc000, rand_data());
      #1;
      // First piece already on the output in the same cycle
      check_val("umi_out_valid", umi_out_valid, 1);
      check_val("umi_out_cmd", umi_out_cmd, exp_cmd[0]);
      check_val("umi_out_dstaddr", umi_out_dstaddr, 64'h5005);
      wait_accept();
      wait_drain();
      check_val("pieces", rx_pieces, 5);
      check_val("fifo_empty", fifo_empty, 1);
      #2 bypass = 1'b0;
      report_test("bypass", e0);
   endtask

   //######################################################################
   // Main sequence and timeout
   //######################################################################

   initial
   begin
      bypass         = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_cmd     = '0;
      umi_in_dstaddr = '0;
      umi_in_srcaddr = '0;
      umi_in_data    = '0;
      umi_out_ready  = 1'b1;
      test_reset();
      test_pass_through();
      test_aligned();
      test_unaligned();
      test_backpressure();
      test_bypass();
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      while (cycles < 200 + 40 * planned)   // Limit grows with each expected piece
      begin
         @(posedge umi_in_clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, %0d pieces still outstanding",
               cycles, exp_cmd.size());
      $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- umi_async_fifo.sv
`timescale 1ns/1ns

module umi_async_fifo
  #(parameter int DW    = 160,
    parameter int DEPTH = 4         // Power of two and at least 2
    )
   (// Write side
    input  logic          wr_clk,
    input  logic          wr_nreset,
    input  logic          wr_en,
    input  logic [DW-1:0] wr_din,
    output logic          wr_full,
    // Read side
    input  logic          rd_clk,
    input  logic          rd_nreset,
    input  logic          rd_en,
    output logic [DW-1:0] rd_dout,
    output logic          rd_empty
    );

   localparam int addr_w = $clog2(DEPTH);
   localparam int ptr_w  = addr_w + 1;                  // Extra wrap bit

   // Top two Gray bits differ when the write pointer is a lap ahead
   localparam logic [ptr_w-1:0] full_mask = ptr_w'(3) << (ptr_w - 2);

   logic [DW-1:0]    mem [DEPTH];

   logic [ptr_w-1:0] wr_bin;
   logic [ptr_w-1:0] wr_gray;
   logic [ptr_w-1:0] wr_bin_next;
   logic [ptr_w-1:0] rd_gray_s1;   // Read pointer in write domain
   logic [ptr_w-1:0] rd_gray_s2;
   logic             wr_push;

   logic [ptr_w-1:0] rd_bin;
   logic [ptr_w-1:0] rd_gray;
   logic [ptr_w-1:0] rd_bin_next;
   logic [ptr_w-1:0] wr_gray_s1;   // Write pointer in read domain
   logic [ptr_w-1:0] wr_gray_s2;
   logic             rd_pop;

   function automatic logic [ptr_w-1:0] bin2gray(input logic [ptr_w-1:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   //######################################################################
   // Write domain
   //######################################################################

   assign wr_push     = wr_en & ~wr_full;          // Writes while full dropped
   assign wr_bin_next = wr_bin + ptr_w'(1);

   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         wr_bin  <= '0;
         wr_gray <= '0;
      end
      else if (wr_push)
      begin
         wr_bin  <= wr_bin_next;
         wr_gray <= bin2gray(wr_bin_next);
      end
   end

   always_ff @(posedge wr_clk)
   begin
      if (wr_push)
      begin
         mem[wr_bin[addr_w-1:0]] <= wr_din;
      end
   end

   // Two-flop synchronizer
   always_ff @(posedge wr_clk or negedge wr_nreset)
   begin
      if (!wr_nreset)
      begin
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
      end
   end

   assign wr_full = (wr_gray == (rd_gray_s2 ^ full_mask));

   //######################################################################
   // Read domain
   //######################################################################

   assign rd_pop      = rd_en & ~rd_empty;         // Reads while empty dropped
   assign rd_bin_next = rd_bin + ptr_w'(1);

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         rd_bin  <= '0;
         rd_gray <= '0;
      end
      else if (rd_pop)
      begin
         rd_bin  <= rd_bin_next;
         rd_gray <= bin2gray(rd_bin_next);
      end
   end

   always_ff @(posedge rd_clk or negedge rd_nreset)
   begin
      if (!rd_nreset)
      begin
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
      end
   end

   assign rd_empty = (rd_gray == wr_gray_s2);
   assign rd_dout  = mem[rd_bin[addr_w-1:0]];      // Show-ahead head word

endmodule

//--- umi_fifo_flex.sv
`timescale 1ns/1ns

module umi_fifo_flex
  #(parameter int AW     = 64,
    parameter int IDW    = 256,
    parameter int ODW    = 64,
    parameter int DEPTH  = 4,
    parameter int SPLIT  = 0,       // Also split at output beat boundaries
    parameter int BYPASS = 0        // Build without the FIFO
    )
   (input  logic                       bypass,     // Run-time bypass
    output logic                       fifo_full,
    output logic                       fifo_empty,
    // Input side
    input  logic                       umi_in_clk,
    input  logic                       umi_in_nreset,
    input  logic                       umi_in_valid,
    input  logic [umi_pkg::umi_cw-1:0] umi_in_cmd,
    input  logic [AW-1:0]              umi_in_dstaddr,
    input  logic [AW-1:0]              umi_in_srcaddr,
    input  logic [IDW-1:0]             umi_in_data,
    output logic                       umi_in_ready,
    // Output side
    input  logic                       umi_out_clk,
    input  logic                       umi_out_nreset,
    output logic                       umi_out_valid,
    output logic [umi_pkg::umi_cw-1:0] umi_out_cmd,
    output logic [AW-1:0]              umi_out_dstaddr,
    output logic [AW-1:0]              umi_out_srcaddr,
    output logic [ODW-1:0]             umi_out_data,
    input  logic                       umi_out_ready
    );

   import umi_pkg::*;

   localparam int fw = umi_cw + AW + AW + ODW;     // FIFO word width

   logic [1:0]        start_q;
   logic              enable;
   logic              use_bypass;

   // Splitter output
   logic              pc_valid;
   logic [umi_cw-1:0] pc_cmd;
   logic [AW-1:0]     pc_dstaddr;
   logic [AW-1:0]     pc_srcaddr;
   logic [ODW-1:0]    pc_data;
   logic              pc_ready;

   logic [fw-1:0]     fifo_din;
   logic [fw-1:0]     fifo_dout;

   //######################################################################
   // Start-up delay
   //######################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         start_q <= 2'b00;
      end
      else
      begin
         start_q <= {start_q[0], 1'b1};
      end
   end

   assign enable     = start_q[1];
   assign use_bypass = bypass | (BYPASS != 0);

   //######################################################################
   // Splitter
   //######################################################################

   umi_split
     #(.AW    (AW),
       .IDW   (IDW),
       .ODW   (ODW),
       .SPLIT (SPLIT))
   u_split
     (.umi_in_clk    (umi_in_clk),
      .umi_in_nreset (umi_in_nreset),
      .enable        (enable),
      .in_valid      (umi_in_valid),
      .in_cmd        (umi_in_cmd),
      .in_dstaddr    (umi_in_dstaddr),
      .in_srcaddr    (umi_in_srcaddr),
      .in_data       (umi_in_data),
      .in_ready      (umi_in_ready),
      .pc_valid      (pc_valid),
      .pc_cmd        (pc_cmd),
      .pc_dstaddr    (pc_dstaddr),
      .pc_srcaddr    (pc_srcaddr),
      .pc_data       (pc_data),
      .pc_ready      (pc_ready));

   // FIFO word with cmd in the low bits
   assign fifo_din = {pc_data, pc_srcaddr, pc_dstaddr, pc_cmd};

   assign pc_ready = use_bypass ? umi_out_ready : ~fifo_full;

   //######################################################################
   // Dual-clock FIFO
   //######################################################################

   generate
      if (BYPASS != 0)
      begin : g_no_fifo
         assign fifo_full  = ~umi_out_ready;       // Mirrors output stall
         assign fifo_empty = 1'b1;
         assign fifo_dout  = '0;
      end
      else
      begin : g_fifo
         umi_async_fifo
           #(.DW    (fw),
             .DEPTH (DEPTH))
         u_fifo
           (.wr_clk    (umi_in_clk),
            .wr_nreset (umi_in_nreset),
            .wr_en     (pc_valid & ~use_bypass),
            .wr_din    (fifo_din),
            .wr_full   (fifo_full),
            .rd_clk    (umi_out_clk),
            .rd_nreset (umi_out_nreset),
            .rd_en     (umi_out_ready & ~use_bypass),
            .rd_dout   (fifo_dout),
            .rd_empty  (fifo_empty));
      end
   endgenerate

   //######################################################################
   // Output select
   //######################################################################

   assign umi_out_valid   = use_bypass ? pc_valid : ~fifo_empty;
   assign umi_out_cmd     = use_bypass ? pc_cmd     : fifo_dout[0 +: umi_cw];
   assign umi_out_dstaddr = use_bypass ? pc_dstaddr : fifo_dout[umi_cw +: AW];
   assign umi_out_srcaddr = use_bypass ? pc_srcaddr : fifo_dout[umi_cw+AW +: AW];
   assign umi_out_data    = use_bypass ? pc_data    : fifo_dout[umi_cw+2*AW +: ODW];

endmodule

//--- umi_pkg.sv
package umi_pkg;

   //######################################################################
   // Command word layout
   //######################################################################

   localparam int umi_cw     = 32;
   localparam int opcode_lsb = 0;
   localparam int opcode_w   = 5;
   localparam int size_lsb   = 5;
   localparam int size_w     = 3;
   localparam int len_lsb    = 8;
   localparam int len_w      = 8;
   localparam int eom_pos    = 22;    // qos/prot sit between len and eom

   // Request opcodes are odd and responses even
   typedef enum logic [4:0] {
      UMI_INVALID    = 5'h00,
      UMI_REQ_READ   = 5'h01,
      UMI_RESP_READ  = 5'h02,
      UMI_REQ_WRITE  = 5'h03,
      UMI_RESP_WRITE = 5'h04,
      UMI_REQ_POSTED = 5'h05
   } umi_opcode_e;

   //######################################################################
   // Field access
   //######################################################################

   function automatic umi_opcode_e cmd_opcode(input logic [umi_cw-1:0] cmd);
      return umi_opcode_e'(cmd[opcode_lsb +: opcode_w]);
   endfunction

   function automatic logic [size_w-1:0] cmd_size(input logic [umi_cw-1:0] cmd);
      return cmd[size_lsb +: size_w];
   endfunction

   // Element count minus one
   function automatic logic [len_w-1:0] cmd_len(input logic [umi_cw-1:0] cmd);
      return cmd[len_lsb +: len_w];
   endfunction

   function automatic logic cmd_eom(input logic [umi_cw-1:0] cmd);
      return cmd[eom_pos];
   endfunction

   // Rewrites len and eom and keeps all other fields
   function automatic logic [umi_cw-1:0] cmd_set_len_eom(input logic [umi_cw-1:0] cmd,
                                                         input logic [len_w-1:0]  len,
                                                         input logic              eom);
      logic [umi_cw-1:0] result;
      result                     = cmd;
      result[len_lsb +: len_w]   = len;
      result[eom_pos]            = eom;
      return result;
   endfunction

endpackage

//--- umi_split.sv
`timescale 1ns/1ns

module umi_split
  #(parameter int AW    = 64,
    parameter int IDW   = 256,
    parameter int ODW   = 64,
    parameter int SPLIT = 0
    )
   (input  logic                      umi_in_clk,
    input  logic                      umi_in_nreset,
    input  logic                      enable,       // From start-up register
    // Input transaction
    input  logic                      in_valid,
    input  logic [umi_pkg::umi_cw-1:0] in_cmd,
    input  logic [AW-1:0]             in_dstaddr,
    input  logic [AW-1:0]             in_srcaddr,
    input  logic [IDW-1:0]            in_data,
    output logic                      in_ready,
    // Output pieces
    output logic                      pc_valid,
    output logic [umi_pkg::umi_cw-1:0] pc_cmd,
    output logic [AW-1:0]             pc_dstaddr,
    output logic [AW-1:0]             pc_srcaddr,
    output logic [ODW-1:0]            pc_data,
    input  logic                      pc_ready
    );

   import umi_pkg::*;

   localparam int bytes = ODW / 8;                      // Bytes per output beat
   localparam int off_w = (bytes > 1) ? $clog2(bytes) : 1;

   // Packet latch holds what is left of a split transaction
   logic              latch_valid;
   logic [umi_cw-1:0] latch_cmd;
   logic [AW-1:0]     latch_dstaddr;
   logic [AW-1:0]     latch_srcaddr;
   logic [IDW-1:0]    latch_data;

   // Current transaction from new input or latched remainder
   logic [umi_cw-1:0] cur_cmd;
   logic [AW-1:0]     cur_dstaddr;
   logic [AW-1:0]     cur_srcaddr;
   logic [IDW-1:0]    cur_data;

   logic [size_w-1:0] size;
   logic [len_w-1:0]  len;
   logic [16:0]       nbytes;       // Total payload bytes
   logic [off_w-1:0]  offset;       // Position within output beat
   logic [16:0]       room;         // Bytes left up to beat boundary
   logic [16:0]       piece_elems;
   logic [len_w-1:0]  piece_len;
   logic [len_w-1:0]  rem_len;
   logic              do_split;
   logic              pc_fire;

   //######################################################################
   // Source select
   //######################################################################

   assign cur_cmd     = latch_valid ? latch_cmd     : in_cmd;
   assign cur_dstaddr = latch_valid ? latch_dstaddr : in_dstaddr;
   assign cur_srcaddr = latch_valid ? latch_srcaddr : in_srcaddr;
   assign cur_data    = latch_valid ? latch_data    : in_data;

   assign size = cmd_size(cur_cmd);
   assign len  = cmd_len(cur_cmd);

   //######################################################################
   // Split decision
   //######################################################################

   assign nbytes = (17'(len) + 17'd1) << size;

   // Remainders start aligned, so offset comes out zero for them
   assign offset = (SPLIT != 0) ? cur_dstaddr[off_w-1:0] : '0;

   assign room        = 17'(bytes) - 17'(offset);
   assign do_split    = (17'(offset) + nbytes) > 17'(bytes);
   assign piece_elems = room >> size;
   assign piece_len   = len_w'(piece_elems - 17'd1);
   assign rem_len     = len_w'(17'(len) - piece_elems);

   //######################################################################
   // Piece out
   //######################################################################

   assign pc_valid   = enable & (latch_valid | in_valid);
   assign pc_cmd     = do_split ? cmd_set_len_eom(cur_cmd, piece_len, 1'b0) : cur_cmd;
   assign pc_dstaddr = cur_dstaddr;
   assign pc_srcaddr = cur_srcaddr;

   generate
      if (ODW > IDW)
      begin : g_widen
         assign pc_data = {{(ODW-IDW){1'b0}}, cur_data};   // Zero-extend only
      end
      else
      begin : g_narrow
         assign pc_data = cur_data[ODW-1:0];
      end
   endgenerate

   // No new input while a remainder is pending
   assign in_ready = enable & ~latch_valid & pc_ready;

   assign pc_fire = pc_valid & pc_ready;

   //######################################################################
   // Remainder latch
   //######################################################################

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         latch_valid <= 1'b0;
      end
      else if (pc_fire)
      begin
         latch_valid <= do_split;
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (pc_fire)
      begin
         // Original eom rides along until the last piece
         latch_cmd     <= cmd_set_len_eom(cur_cmd, rem_len, cmd_eom(cur_cmd));
         latch_dstaddr <= cur_dstaddr + AW'(room);
         latch_srcaddr <= cur_srcaddr + AW'(room);
         latch_data    <= cur_data >> {room, 3'b000};   // Drop bytes sent
      end
   end

endmodule
